// ==== ecc_pkg.sv ====
package ecc_pkg;

    localparam int ECC_DATA_WIDTH   = 96;
    localparam int ECC_PARITY_WIDTH = 8;

    typedef logic [ECC_DATA_WIDTH-1:0]   ecc_data_t;   // data word, also the flip mask
    typedef logic [ECC_PARITY_WIDTH-1:0] ecc_parity_t; // check word or syndrome

    typedef struct packed {
        logic dbit_err; // uncorrectable, two or more bits
        logic sbit_err; // one bit, data or check
    } ecc_status_t;

    localparam ecc_parity_t ECC_NO_SYNDROME = '0;

    // check column of each data bit, entry k belongs to data bit k
    // bit j of an entry set means the data bit feeds check bit j
    // every column has odd weight of three or more, so a double error never aliases
    localparam ecc_parity_t ECC_H_COLUMNS [ECC_DATA_WIDTH] = '{
        8'b10000011, // d0
        8'b10000101,
        8'b10000110,
        8'b00000111,
        8'b10001001,
        8'b10001010,
        8'b00001011,
        8'b10001100,
        8'b00001101,
        8'b00001110,
        8'b10001111,
        8'b10010001,
        8'b10010010,
        8'b00010011,
        8'b10010100,
        8'b00010101,
        8'b00010110, // d16
        8'b10010111,
        8'b10011000,
        8'b00011001,
        8'b00011010,
        8'b10011011,
        8'b00011100,
        8'b10011101,
        8'b10011110,
        8'b00011111,
        8'b10100001,
        8'b10100010,
        8'b00100011,
        8'b10100100,
        8'b00100101,
        8'b00100110,
        8'b10100111, // d32
        8'b10101000,
        8'b00101001,
        8'b00101010,
        8'b10101011,
        8'b00101100,
        8'b10101101,
        8'b10101110,
        8'b00101111,
        8'b10110000,
        8'b00110001,
        8'b00110010,
        8'b10110011,
        8'b00110100,
        8'b10110101,
        8'b10110110,
        8'b00110111, // d48
        8'b00111000,
        8'b10111001,
        8'b10111010,
        8'b00111011,
        8'b10111100,
        8'b00111101,
        8'b00111110,
        8'b10111111,
        8'b11000001,
        8'b11000010,
        8'b01000011,
        8'b11000100,
        8'b01000101,
        8'b01000110,
        8'b11000111,
        8'b11001000, // d64
        8'b01001001,
        8'b01001010,
        8'b11001011,
        8'b01001100,
        8'b11001101,
        8'b11001110,
        8'b01001111,
        8'b11010000,
        8'b01010001,
        8'b01010010,
        8'b11010011,
        8'b01010100,
        8'b11010101,
        8'b11010110,
        8'b01010111,
        8'b01011000, // d80
        8'b11011001,
        8'b11011010,
        8'b01011011,
        8'b11011100,
        8'b01011101,
        8'b01011110,
        8'b11011111,
        8'b11100000,
        8'b01100001,
        8'b01100010,
        8'b11100011,
        8'b01100100,
        8'b11100101,
        8'b11100110,
        8'b01100111  // d95
    };

endpackage

// ==== ecc_encoder.sv ====
`timescale 1ns/1ns

module ecc_encoder (
    input  ecc_pkg::ecc_data_t   data,
    output ecc_pkg::ecc_parity_t parity
);

    // row j of the check matrix, picked out of the column table
    function automatic ecc_pkg::ecc_data_t row_select(input int j);
        ecc_pkg::ecc_data_t sel;
        sel = '0;
        for (int k = 0; k < ecc_pkg::ECC_DATA_WIDTH; k++) begin
            sel[k] = ecc_pkg::ECC_H_COLUMNS[k][j];
        end
        return sel;
    endfunction

    genvar j;
    generate
        for (j = 0; j < ecc_pkg::ECC_PARITY_WIDTH; j++) begin : g_check
            localparam ecc_pkg::ecc_data_t ROW_SEL = row_select(j);

            // even parity over the data bits feeding this check bit
            assign parity[j] = ^(data & ROW_SEL);
        end
    endgenerate

endmodule

// ==== ecc_syndrome_decoder.sv ====
`timescale 1ns/1ns

module ecc_syndrome_decoder (
    input  ecc_pkg::ecc_parity_t syndrome,
    output ecc_pkg::ecc_data_t   mask,
    output ecc_pkg::ecc_status_t status
);

    ecc_pkg::ecc_parity_t syn_low;
    logic                 col_hit;
    logic                 par_hit;
    logic                 syn_zero;

    // one comparator per data bit, columns are distinct so at most one fires
    genvar k;
    generate
        for (k = 0; k < ecc_pkg::ECC_DATA_WIDTH; k++) begin : g_mask
            assign mask[k] = (syndrome == ecc_pkg::ECC_H_COLUMNS[k]);
        end
    endgenerate

    assign syn_zero = (syndrome == ecc_pkg::ECC_NO_SYNDROME);
    assign col_hit  = |mask;

    // a lone syndrome bit points at a flipped check bit, nothing to fix in data
    assign syn_low = syndrome - 8'd1;
    assign par_hit = !syn_zero && ((syndrome & syn_low) == ecc_pkg::ECC_NO_SYNDROME);

    always_comb begin
        status = '0;
        if (!syn_zero) begin
            if (col_hit || par_hit) begin
                status.sbit_err = 1'b1;
            end else begin
                // even weight or unused odd code
                status.dbit_err = 1'b1;
            end
        end
    end

endmodule

// ==== ecc_96_cal.sv ====
`timescale 1ns/1ns

module ecc_96_cal (
    input  ecc_pkg::ecc_data_t   data_in,
    input  ecc_pkg::ecc_parity_t parity_in,
    input  logic                 bypass,
    output ecc_pkg::ecc_data_t   data_out,
    output ecc_pkg::ecc_parity_t parity_out,
    output ecc_pkg::ecc_data_t   mask,
    output ecc_pkg::ecc_status_t status
);

    ecc_pkg::ecc_parity_t syndrome;
    ecc_pkg::ecc_status_t raw_status;

    // check bits of the word as received
    ecc_encoder u_encoder (
        .data   (data_in),
        .parity (parity_out)
    );

    assign syndrome = parity_in ^ parity_out; // zero when the stored parity agrees

    ecc_syndrome_decoder u_decoder (
        .syndrome (syndrome),
        .mask     (mask),
        .status   (raw_status)
    );

    // bypass hands the word through untouched and hides the flags
    // mask stays visible either way
    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign status   = bypass ? '0 : raw_status;

endmodule

// ==== tb_ecc_vectors.svh ====
typedef enum logic [1:0] {
    ERR_NONE,
    ERR_DATA,
    ERR_PARITY,
    ERR_DOUBLE
} err_kind_t;

typedef struct packed {
    logic                 rand_data;  // pattern replaced by a random word
    ecc_pkg::ecc_data_t   pattern;
    err_kind_t            kind;
    int                   flip_a;     // 0..95 data bit, 96..103 check bit
    int                   flip_b;
    logic                 bypass;
    ecc_pkg::ecc_status_t exp_status;
} vector_t;

localparam int PB = ecc_pkg::ECC_DATA_WIDTH; // first check-bit position in the flip index

// {dbit_err, sbit_err}
localparam ecc_pkg::ecc_status_t ST_CLEAN = 2'b00;
localparam ecc_pkg::ecc_status_t ST_SBIT  = 2'b01;
localparam ecc_pkg::ecc_status_t ST_DBIT  = 2'b10;

vector_t vec_table [$];
string   vec_name  [$];

task automatic add_vector(
    input string                name,
    input logic                 rand_data,
    input ecc_pkg::ecc_data_t   pattern,
    input err_kind_t            kind,
    input int                   flip_a,
    input int                   flip_b,
    input logic                 bypass,
    input ecc_pkg::ecc_status_t exp_status
);
    vector_t v;
    v.rand_data  = rand_data;
    v.pattern    = pattern;
    v.kind       = kind;
    v.flip_a     = flip_a;
    v.flip_b     = flip_b;
    v.bypass     = bypass;
    v.exp_status = exp_status;
    vec_table.push_back(v);
    vec_name.push_back(name);
endtask

task automatic load_vectors();
    // name, random, pattern, error kind, flip a, flip b, bypass, expected status
    add_vector("clean_zero",     1'b0, '0, ERR_NONE,   0,      0,      1'b0, ST_CLEAN);
    add_vector("clean_ones",     1'b0, '1, ERR_NONE,   0,      0,      1'b0, ST_CLEAN);
    add_vector("clean_rand_a",   1'b1, '0, ERR_NONE,   0,      0,      1'b0, ST_CLEAN);
    add_vector("clean_rand_b",   1'b1, '0, ERR_NONE,   0,      0,      1'b0, ST_CLEAN);
    add_vector("data_bit_0",     1'b1, '0, ERR_DATA,   0,      0,      1'b0, ST_SBIT);
    add_vector("data_bit_95",    1'b1, '0, ERR_DATA,   95,     0,      1'b0, ST_SBIT);
    add_vector("data_bit_47",    1'b0, '0, ERR_DATA,   47,     0,      1'b0, ST_SBIT);
    add_vector("data_bit_63",    1'b0, '1, ERR_DATA,   63,     0,      1'b0, ST_SBIT);
    add_vector("data_bit_18",    1'b1, '0, ERR_DATA,   18,     0,      1'b0, ST_SBIT);
    add_vector("parity_bit_0",   1'b1, '0, ERR_PARITY, PB + 0, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_1",   1'b1, '0, ERR_PARITY, PB + 1, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_2",   1'b0, '1, ERR_PARITY, PB + 2, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_3",   1'b1, '0, ERR_PARITY, PB + 3, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_4",   1'b0, '0, ERR_PARITY, PB + 4, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_5",   1'b1, '0, ERR_PARITY, PB + 5, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_6",   1'b1, '0, ERR_PARITY, PB + 6, 0,      1'b0, ST_SBIT);
    add_vector("parity_bit_7",   1'b1, '0, ERR_PARITY, PB + 7, 0,      1'b0, ST_SBIT);
    add_vector("double_dd",      1'b1, '0, ERR_DOUBLE, 3,      77,     1'b0, ST_DBIT);
    add_vector("double_dd_adj",  1'b0, '1, ERR_DOUBLE, 94,     95,     1'b0, ST_DBIT);
    add_vector("double_dp",      1'b1, '0, ERR_DOUBLE, 10,     PB + 4, 1'b0, ST_DBIT);
    add_vector("double_pp",      1'b1, '0, ERR_DOUBLE, PB + 0, PB + 7, 1'b0, ST_DBIT);
    add_vector("bypass_clean",   1'b1, '0, ERR_NONE,   0,      0,      1'b1, ST_CLEAN);
    add_vector("bypass_single",  1'b1, '0, ERR_DATA,   5,      0,      1'b1, ST_CLEAN);
    add_vector("bypass_double",  1'b1, '0, ERR_DOUBLE, 20,     PB + 3, 1'b1, ST_CLEAN);
endtask

// ==== tb_ecc_96_cal.sv ====
`timescale 1ns/1ns

module tb_ecc_96_cal;

    localparam int RESET_TIMEOUT = 50; // cycles

    logic clk = 1'b0;
    logic rst_n;

    ecc_pkg::ecc_data_t   data_in;
    ecc_pkg::ecc_parity_t parity_in;
    logic                 bypass;
    ecc_pkg::ecc_data_t   data_out;
    ecc_pkg::ecc_parity_t parity_out;
    ecc_pkg::ecc_data_t   mask;
    ecc_pkg::ecc_status_t status;

    integer seed = 87888;
    int     data_errs   = 0;
    int     parity_errs = 0;
    int     status_errs = 0;

    `include "tb_ecc_vectors.svh"

    ecc_96_cal u_dut (
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .mask       (mask),
        .status     (status)
    );

    always #2 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

    // check bits straight from the column definition
    function automatic ecc_pkg::ecc_parity_t model_parity(input ecc_pkg::ecc_data_t d);
        ecc_pkg::ecc_parity_t p;
        p = '0;
        for (int j = 0; j < ecc_pkg::ECC_PARITY_WIDTH; j++) begin
            for (int k = 0; k < ecc_pkg::ECC_DATA_WIDTH; k++) begin
                if (ecc_pkg::ECC_H_COLUMNS[k][j]) begin
                    p[j] = p[j] ^ d[k];
                end
            end
        end
        return p;
    endfunction

    function automatic ecc_pkg::ecc_data_t random_word();
        ecc_pkg::ecc_data_t d;
        d[31:0]  = $random(seed);
        d[63:32] = $random(seed);
        d[95:64] = $random(seed);
        return d;
    endfunction

    task automatic flip_bit(
        input int                      idx,
        inout ecc_pkg::ecc_data_t      d,
        inout ecc_pkg::ecc_parity_t    p
    );
        if (idx < ecc_pkg::ECC_DATA_WIDTH) begin
            d = d ^ (ecc_pkg::ecc_data_t'(1) << idx);
        end else begin
            p = p ^ (ecc_pkg::ecc_parity_t'(1) << (idx - ecc_pkg::ECC_DATA_WIDTH));
        end
    endtask

    task automatic check_data(
        input string              name,
        input string              what,
        input ecc_pkg::ecc_data_t exp,
        input ecc_pkg::ecc_data_t act
    );
        if (act !== exp) begin
            data_errs++;
            $display("Fail %s %s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_parity(
        input string                name,
        input ecc_pkg::ecc_parity_t exp,
        input ecc_pkg::ecc_parity_t act
    );
        if (act !== exp) begin
            parity_errs++;
            $display("Fail %s parity_out: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(
        input string                name,
        input ecc_pkg::ecc_status_t exp,
        input ecc_pkg::ecc_status_t act
    );
        if (act !== exp) begin
            status_errs++;
            $display("Fail %s status: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic run_vector(input int i);
        vector_t              v;
        ecc_pkg::ecc_data_t   clean;
        ecc_pkg::ecc_data_t   bad_data;
        ecc_pkg::ecc_parity_t bad_parity;
        ecc_pkg::ecc_data_t   exp_data;
        ecc_pkg::ecc_data_t   exp_mask;
        v = vec_table[i];
        clean = v.rand_data ? random_word() : v.pattern;
        bad_data   = clean;
        bad_parity = model_parity(clean);
        case (v.kind)
            ERR_DATA, ERR_PARITY: flip_bit(v.flip_a, bad_data, bad_parity);
            ERR_DOUBLE: begin
                flip_bit(v.flip_a, bad_data, bad_parity);
                flip_bit(v.flip_b, bad_data, bad_parity);
            end
            default: ;
        endcase

        // only a lone data-bit flip shows up in the mask, bypass or not
        exp_mask = '0;
        if (v.kind == ERR_DATA) begin
            exp_mask = ecc_pkg::ecc_data_t'(1) << v.flip_a;
        end
        exp_data = (v.kind == ERR_DATA && !v.bypass) ? clean : bad_data;

        @(posedge clk);
        data_in   <= bad_data;
        parity_in <= bad_parity;
        bypass    <= v.bypass;
        @(negedge clk);

        check_data(vec_name[i], "data_out", exp_data, data_out);
        check_data(vec_name[i], "mask", exp_mask, mask);
        check_parity(vec_name[i], model_parity(bad_data), parity_out);
        check_status(vec_name[i], v.exp_status, status);
    endtask

    initial begin
        int wait_cycles;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        load_vectors();

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end

        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Test FAILED");
        end else begin
            for (int i = 0; i < vec_table.size(); i++) begin
                run_vector(i);
            end
            $display("errors: data %0d parity %0d status %0d over %0d vectors",
                     data_errs, parity_errs, status_errs, vec_table.size());
            if (data_errs + parity_errs + status_errs == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
ecc_pkg.sv
ecc_encoder.sv
ecc_syndrome_decoder.sv
ecc_96_cal.sv
tb_ecc_96_cal.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns --top-module tb_ecc_96_cal \
    -f compile.f --Mdir obj_dir -o tb_ecc_96_cal
./obj_dir/tb_ecc_96_cal | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation passed"
